// File: verilog.f
verilog/bp_pkg.sv
verilog/resolve_if.sv
verilog/branch_predictor.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/bp_core_top.sv
dv/tb_bp_core.sv

// File: run.sh
#!/bin/sh
# Compile the core and testbench with Verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f verilog.f --top-module tb_bp_core \
    -Mdir obj_dir -o sim_tb_bp_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_bp_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// File: dv/tb_bp_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bp_core;

    localparam int RETIRE_TIMEOUT = 50;

    logic        clk_i;
    logic        rst_ni;
    logic        imem_we_i;
    logic [3:0]  imem_waddr_i;
    logic [31:0] imem_wdata_i;
    logic        retire_vld_o;
    logic [31:0] retire_pc_o;
    logic        retire_wren_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_data_o;

    logic [31:0] prog [16];
    logic [31:0] exp_pc [$];
    logic        exp_wren [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          exp_gap [$];

    int value_errs;
    int timing_errs;
    int timeout_errs;
    int cyc;
    int prev_cyc;
    int waited;
    logic got;

    bp_core_top #(
        .BP_INDEX_W (4)
    ) i_bp_core_top (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .imem_we_i     (imem_we_i),
        .imem_waddr_i  (imem_waddr_i),
        .imem_wdata_i  (imem_wdata_i),
        .retire_vld_o  (retire_vld_o),
        .retire_pc_o   (retire_pc_o),
        .retire_wren_o (retire_wren_o),
        .retire_rd_o   (retire_rd_o),
        .retire_data_o (retire_data_o)
    );

    always #50 clk_i = ~clk_i;

    // RV32I instruction encoders
    function automatic logic [31:0] encode_r(int funct7, int funct3, int rd, int rs1, int rs2);
        return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_addi(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_branch(int funct3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] encode_jal(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Gap counts cycles since the previous retirement or since reset release for row 0
    task automatic add_retire_row(int pc, int wren, int rd, logic [31:0] data, int gap);
        exp_pc.push_back(pc);
        exp_wren.push_back(wren != 0);
        exp_rd.push_back(rd[4:0]);
        exp_data.push_back(data);
        exp_gap.push_back(gap);
    endtask

    task automatic check_retirement(int row);
        assert (retire_pc_o == exp_pc[row]) else begin
            value_errs++;
            $display("FAILED %0t: retirement %0d pc %h, expected %h",
                     $time, row, retire_pc_o, exp_pc[row]);
        end
        assert (retire_wren_o == exp_wren[row]) else begin
            value_errs++;
            $display("FAILED %0t: retirement %0d (pc %h) wren %b, expected %b",
                     $time, row, retire_pc_o, retire_wren_o, exp_wren[row]);
        end
        if (exp_wren[row]) begin
            assert ((retire_rd_o == exp_rd[row]) && (retire_data_o == exp_data[row])) else begin
                value_errs++;
                $display("FAILED %0t: retirement %0d (pc %h) wrote x%0d=%h, expected x%0d=%h",
                         $time, row, retire_pc_o, retire_rd_o, retire_data_o,
                         exp_rd[row], exp_data[row]);
            end
        end
        assert ((cyc - prev_cyc) == exp_gap[row]) else begin
            timing_errs++;
            $display("FAILED %0t: retirement %0d (pc %h) after %0d cycles, expected %0d",
                     $time, row, retire_pc_o, cyc - prev_cyc, exp_gap[row]);
        end
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        imem_we_i    = 1'b0;
        imem_waddr_i = '0;
        imem_wdata_i = '0;
        value_errs   = 0;
        timing_errs  = 0;
        timeout_errs = 0;

        prog[0]  = encode_addi(1, 0, 5);
        prog[1]  = encode_addi(2, 0, 0);
        // Loop body at pc 8
        prog[2]  = encode_r(0, 0, 2, 2, 1);
        prog[3]  = encode_addi(1, 1, -1);
        prog[4]  = encode_branch(1, 1, 0, -8);
        // Dependent chain sub, xor, and, or, slt
        prog[5]  = encode_r(32, 0, 3, 1, 2);
        prog[6]  = encode_r(0, 4, 4, 3, 2);
        prog[7]  = encode_r(0, 7, 5, 4, 3);
        prog[8]  = encode_r(0, 6, 6, 5, 2);
        prog[9]  = encode_r(0, 2, 7, 5, 2);
        prog[10] = encode_branch(0, 7, 0, 8);
        prog[11] = encode_jal(8, 8);
        prog[12] = encode_addi(9, 0, 1);
        prog[13] = encode_addi(10, 2, 1);
        prog[14] = '0;
        prog[15] = '0;

        // Fetched in the release cycle, retired four cycles later
        add_retire_row(0, 1, 1, 32'd5, 5);
        add_retire_row(4, 1, 2, 32'd0, 1);
        // Iterations 1 and 2 mispredict the taken bne
        add_retire_row(8, 1, 2, 32'd5, 1);
        add_retire_row(12, 1, 1, 32'd4, 1);
        add_retire_row(16, 0, 0, 32'd0, 1);
        add_retire_row(8, 1, 2, 32'd9, 4);
        add_retire_row(12, 1, 1, 32'd3, 1);
        add_retire_row(16, 0, 0, 32'd0, 1);
        // Iterations 3 and 4 predicted taken
        add_retire_row(8, 1, 2, 32'd12, 4);
        add_retire_row(12, 1, 1, 32'd2, 1);
        add_retire_row(16, 0, 0, 32'd0, 1);
        add_retire_row(8, 1, 2, 32'd14, 1);
        add_retire_row(12, 1, 1, 32'd1, 1);
        add_retire_row(16, 0, 0, 32'd0, 1);
        // Final bne falls through against the prediction
        add_retire_row(8, 1, 2, 32'd15, 1);
        add_retire_row(12, 1, 1, 32'd0, 1);
        add_retire_row(16, 0, 0, 32'd0, 1);
        add_retire_row(20, 1, 3, 32'hffff_fff1, 4);
        add_retire_row(24, 1, 4, 32'hffff_fffe, 1);
        add_retire_row(28, 1, 5, 32'hffff_fff0, 1);
        add_retire_row(32, 1, 6, 32'hffff_ffff, 1);
        add_retire_row(36, 1, 7, 32'd1, 1);
        add_retire_row(40, 0, 0, 32'd0, 1);
        add_retire_row(44, 1, 8, 32'd48, 1);
        add_retire_row(52, 1, 10, 32'd16, 4);

        // Program load while reset is held
        for (int i = 0; i < 16; i++) begin
            @(posedge clk_i);
            imem_we_i    <= 1'b1;
            imem_waddr_i <= 4'(i);
            imem_wdata_i <= prog[i];
        end
        @(posedge clk_i);
        imem_we_i <= 1'b0;
        rst_ni    <= 1'b1;

        // cyc counts the falling edges since release where outputs are sampled
        cyc      = 0;
        prev_cyc = 0;
        for (int row = 0; row < exp_pc.size(); row++) begin
            waited = 0;
            got    = 1'b0;
            while (!got && (waited < RETIRE_TIMEOUT)) begin
                @(negedge clk_i);
                cyc++;
                waited++;
                got = retire_vld_o;
            end
            if (!got) begin
                timeout_errs++;
                $display("Timed out after %0d cycles waiting for retirement %0d (pc %h)",
                         waited, row, exp_pc[row]);
                break;
            end
            check_retirement(row);
            prev_cyc = cyc;
        end

        $display("errors: value %0d, timing %0d, timeout %0d",
                 value_errs, timing_errs, timeout_errs);
        if ((value_errs + timing_errs + timeout_errs) == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/bp_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module bp_core_top #(
    parameter int BP_INDEX_W = 4
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            imem_we_i,
    input  logic [bp_pkg::IMEM_DEPTH_W-1:0] imem_waddr_i,
    input  logic [bp_pkg::XLEN-1:0]         imem_wdata_i,
    output logic                            retire_vld_o,
    output logic [bp_pkg::XLEN-1:0]         retire_pc_o,
    output logic                            retire_wren_o,
    output logic [bp_pkg::REG_ADDR_W-1:0]   retire_rd_o,
    output logic [bp_pkg::XLEN-1:0]         retire_data_o
);

    bp_pkg::insn_t                 ifid_insn;
    logic [bp_pkg::XLEN-1:0]       ifid_pc;
    logic                          ifid_pred_taken;
    logic                          flush;
    logic                          idex_vld;
    logic [bp_pkg::XLEN-1:0]       idex_pc;
    logic [bp_pkg::REG_ADDR_W-1:0] idex_rs1;
    logic [bp_pkg::REG_ADDR_W-1:0] idex_rs2;
    logic [bp_pkg::XLEN-1:0]       idex_rs1_data;
    logic [bp_pkg::XLEN-1:0]       idex_rs2_data;
    logic [bp_pkg::XLEN-1:0]       idex_imm;
    logic [bp_pkg::REG_ADDR_W-1:0] idex_rd;
    logic                          idex_rd_wren;
    logic                          idex_use_imm;
    logic [2:0]                    idex_alu_op;
    logic                          idex_is_branch;
    logic                          idex_is_jal;
    logic [2:0]                    idex_funct3;
    logic                          idex_pred_taken;

    resolve_if i_resolve_if ();

    fetch_stage #(
        .BP_INDEX_W (BP_INDEX_W)
    ) i_fetch_stage (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .imem_we_i         (imem_we_i),
        .imem_waddr_i      (imem_waddr_i),
        .imem_wdata_i      (imem_wdata_i),
        .res               (i_resolve_if.dst),
        .ifid_insn_o       (ifid_insn),
        .ifid_pc_o         (ifid_pc),
        .ifid_pred_taken_o (ifid_pred_taken)
    );

    // Writeback from MEM/WB is also the retirement report
    decode_stage i_decode_stage (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush),
        .ifid_insn_i       (ifid_insn),
        .ifid_pc_i         (ifid_pc),
        .ifid_pred_taken_i (ifid_pred_taken),
        .wb_wren_i         (retire_wren_o),
        .wb_rd_i           (retire_rd_o),
        .wb_data_i         (retire_data_o),
        .idex_vld_o        (idex_vld),
        .idex_pc_o         (idex_pc),
        .idex_rs1_o        (idex_rs1),
        .idex_rs2_o        (idex_rs2),
        .idex_rs1_data_o   (idex_rs1_data),
        .idex_rs2_data_o   (idex_rs2_data),
        .idex_imm_o        (idex_imm),
        .idex_rd_o         (idex_rd),
        .idex_rd_wren_o    (idex_rd_wren),
        .idex_use_imm_o    (idex_use_imm),
        .idex_alu_op_o     (idex_alu_op),
        .idex_is_branch_o  (idex_is_branch),
        .idex_is_jal_o     (idex_is_jal),
        .idex_funct3_o     (idex_funct3),
        .idex_pred_taken_o (idex_pred_taken)
    );

    execute_stage i_execute_stage (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .idex_vld_i        (idex_vld),
        .idex_pc_i         (idex_pc),
        .idex_rs1_i        (idex_rs1),
        .idex_rs2_i        (idex_rs2),
        .idex_rs1_data_i   (idex_rs1_data),
        .idex_rs2_data_i   (idex_rs2_data),
        .idex_imm_i        (idex_imm),
        .idex_rd_i         (idex_rd),
        .idex_rd_wren_i    (idex_rd_wren),
        .idex_use_imm_i    (idex_use_imm),
        .idex_alu_op_i     (idex_alu_op),
        .idex_is_branch_i  (idex_is_branch),
        .idex_is_jal_i     (idex_is_jal),
        .idex_funct3_i     (idex_funct3),
        .idex_pred_taken_i (idex_pred_taken),
        .res               (i_resolve_if.src),
        .flush_o           (flush),
        .wb_wren_o         (retire_wren_o),
        .wb_rd_o           (retire_rd_o),
        .wb_data_o         (retire_data_o),
        .retire_vld_o      (retire_vld_o),
        .retire_pc_o       (retire_pc_o)
    );

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          idex_vld_i,
    input  logic [bp_pkg::XLEN-1:0]       idex_pc_i,
    input  logic [bp_pkg::REG_ADDR_W-1:0] idex_rs1_i,
    input  logic [bp_pkg::REG_ADDR_W-1:0] idex_rs2_i,
    input  logic [bp_pkg::XLEN-1:0]       idex_rs1_data_i,
    input  logic [bp_pkg::XLEN-1:0]       idex_rs2_data_i,
    input  logic [bp_pkg::XLEN-1:0]       idex_imm_i,
    input  logic [bp_pkg::REG_ADDR_W-1:0] idex_rd_i,
    input  logic                          idex_rd_wren_i,
    input  logic                          idex_use_imm_i,
    input  logic [2:0]                    idex_alu_op_i,
    input  logic                          idex_is_branch_i,
    input  logic                          idex_is_jal_i,
    input  logic [2:0]                    idex_funct3_i,
    input  logic                          idex_pred_taken_i,
    resolve_if.src                        res,
    output logic                          flush_o,
    output logic                          wb_wren_o,
    output logic [bp_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [bp_pkg::XLEN-1:0]       wb_data_o,
    output logic                          retire_vld_o,
    output logic [bp_pkg::XLEN-1:0]       retire_pc_o
);

    logic [bp_pkg::XLEN-1:0]       rs1_fwd;
    logic [bp_pkg::XLEN-1:0]       rs2_fwd;
    logic [bp_pkg::XLEN-1:0]       op_b;
    logic [bp_pkg::XLEN-1:0]       alu_res;
    logic                          cond;
    logic                          ex_taken;
    logic                          exmem_vld;
    logic                          exmem_wren;
    logic                          exmem_is_ctrl;
    logic                          exmem_taken;
    logic                          exmem_pred;
    logic [bp_pkg::XLEN-1:0]       exmem_pc;
    logic [bp_pkg::XLEN-1:0]       exmem_result;
    logic [bp_pkg::XLEN-1:0]       exmem_target;
    logic [bp_pkg::REG_ADDR_W-1:0] exmem_rd;

    // EX/MEM has priority over MEM/WB
    function automatic logic [bp_pkg::XLEN-1:0] fwd(
        input logic [bp_pkg::REG_ADDR_W-1:0] rs,
        input logic [bp_pkg::XLEN-1:0]       id_data
    );
        if (exmem_wren && (exmem_rd != '0) && (exmem_rd == rs)) begin
            return exmem_result;
        end
        if (wb_wren_o && (wb_rd_o != '0) && (wb_rd_o == rs)) begin
            return wb_data_o;
        end
        return id_data;
    endfunction

    always_comb begin
        rs1_fwd = fwd(idex_rs1_i, idex_rs1_data_i);
        rs2_fwd = fwd(idex_rs2_i, idex_rs2_data_i);
    end

    assign op_b = idex_use_imm_i ? idex_imm_i : rs2_fwd;

    always_comb begin
        case (idex_alu_op_i)
            bp_pkg::ALU_SUB: alu_res = rs1_fwd - op_b;
            bp_pkg::ALU_AND: alu_res = rs1_fwd & op_b;
            bp_pkg::ALU_OR:  alu_res = rs1_fwd | op_b;
            bp_pkg::ALU_XOR: alu_res = rs1_fwd ^ op_b;
            bp_pkg::ALU_SLT: alu_res = {31'd0, $signed(rs1_fwd) < $signed(op_b)};
            default:         alu_res = rs1_fwd + op_b;
        endcase
    end

    // Branch condition for beq, bne and blt from funct3
    always_comb begin
        case (idex_funct3_i)
            3'b001:  cond = (rs1_fwd != rs2_fwd);
            3'b100:  cond = ($signed(rs1_fwd) < $signed(rs2_fwd));
            default: cond = (rs1_fwd == rs2_fwd);
        endcase
    end

    assign ex_taken = idex_is_jal_i || (idex_is_branch_i && cond);

    assign res.is_ctrl    = exmem_is_ctrl;
    assign res.taken      = exmem_taken;
    assign res.pc         = exmem_pc;
    assign res.target     = exmem_target;
    assign res.pc_plus4   = exmem_pc + 32'd4;
    assign res.mispredict = exmem_is_ctrl && (exmem_pred != exmem_taken);
    assign flush_o        = res.mispredict;

    // EX/MEM drops the wrong-path instruction behind a misprediction
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            exmem_vld     <= 1'b0;
            exmem_wren    <= 1'b0;
            exmem_is_ctrl <= 1'b0;
            exmem_taken   <= 1'b0;
            exmem_pred    <= 1'b0;
        end else if (res.mispredict) begin
            exmem_vld     <= 1'b0;
            exmem_wren    <= 1'b0;
            exmem_is_ctrl <= 1'b0;
            exmem_taken   <= 1'b0;
            exmem_pred    <= 1'b0;
        end else begin
            exmem_vld     <= idex_vld_i;
            exmem_wren    <= idex_rd_wren_i;
            exmem_is_ctrl <= idex_is_branch_i || idex_is_jal_i;
            exmem_taken   <= ex_taken;
            exmem_pred    <= idex_pred_taken_i;
        end
    end

    always_ff @(posedge clk_i) begin
        exmem_pc     <= idex_pc_i;
        exmem_rd     <= idex_rd_i;
        exmem_target <= idex_pc_i + idex_imm_i;
        exmem_result <= idex_is_jal_i ? (idex_pc_i + 32'd4) : alu_res;
    end

    // MEM/WB
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            retire_vld_o <= 1'b0;
            wb_wren_o    <= 1'b0;
        end else begin
            retire_vld_o <= exmem_vld;
            wb_wren_o    <= exmem_wren;
        end
    end

    always_ff @(posedge clk_i) begin
        retire_pc_o <= exmem_pc;
        wb_rd_o     <= exmem_rd;
        wb_data_o   <= exmem_result;
    end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  bp_pkg::insn_t                 ifid_insn_i,
    input  logic [bp_pkg::XLEN-1:0]       ifid_pc_i,
    input  logic                          ifid_pred_taken_i,
    input  logic                          wb_wren_i,
    input  logic [bp_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [bp_pkg::XLEN-1:0]       wb_data_i,
    output logic                          idex_vld_o,
    output logic [bp_pkg::XLEN-1:0]       idex_pc_o,
    output logic [bp_pkg::REG_ADDR_W-1:0] idex_rs1_o,
    output logic [bp_pkg::REG_ADDR_W-1:0] idex_rs2_o,
    output logic [bp_pkg::XLEN-1:0]       idex_rs1_data_o,
    output logic [bp_pkg::XLEN-1:0]       idex_rs2_data_o,
    output logic [bp_pkg::XLEN-1:0]       idex_imm_o,
    output logic [bp_pkg::REG_ADDR_W-1:0] idex_rd_o,
    output logic                          idex_rd_wren_o,
    output logic                          idex_use_imm_o,
    output logic [2:0]                    idex_alu_op_o,
    output logic                          idex_is_branch_o,
    output logic                          idex_is_jal_o,
    output logic [2:0]                    idex_funct3_o,
    output logic                          idex_pred_taken_o
);

    logic [bp_pkg::XLEN-1:0] regs [2 ** bp_pkg::REG_ADDR_W];
    logic [bp_pkg::XLEN-1:0] raw;
    logic [bp_pkg::XLEN-1:0] imm;
    logic [bp_pkg::XLEN-1:0] rs1_data;
    logic [bp_pkg::XLEN-1:0] rs2_data;
    logic [6:0]              funct7;
    logic [2:0]              funct3;
    logic [2:0]              alu_op;
    logic                    vld;
    logic                    rd_wren;
    logic                    use_imm;
    logic                    is_branch;
    logic                    is_jal;

    assign raw    = ifid_insn_i;
    assign funct7 = ifid_insn_i.r.funct7;
    assign funct3 = ifid_insn_i.r.funct3;

    // Unsupported words leave every control low
    always_comb begin
        vld       = 1'b0;
        rd_wren   = 1'b0;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        alu_op    = bp_pkg::ALU_ADD;
        imm       = {{20{ifid_insn_i.i.imm[11]}}, ifid_insn_i.i.imm};
        case (ifid_insn_i.r.opcode)
            bp_pkg::OPC_OP: begin
                vld = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = bp_pkg::ALU_ADD;
                    {7'h20, 3'b000}: alu_op = bp_pkg::ALU_SUB;
                    {7'h00, 3'b111}: alu_op = bp_pkg::ALU_AND;
                    {7'h00, 3'b110}: alu_op = bp_pkg::ALU_OR;
                    {7'h00, 3'b100}: alu_op = bp_pkg::ALU_XOR;
                    {7'h00, 3'b010}: alu_op = bp_pkg::ALU_SLT;
                    default:         vld    = 1'b0;
                endcase
                rd_wren = vld;
            end
            bp_pkg::OPC_OP_IMM: begin
                vld     = (funct3 == 3'b000);
                rd_wren = vld;
                use_imm = 1'b1;
            end
            bp_pkg::OPC_BRANCH: begin
                // beq, bne, blt
                vld       = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b100);
                is_branch = vld;
                imm       = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
            end
            bp_pkg::OPC_JAL: begin
                vld     = 1'b1;
                rd_wren = 1'b1;
                is_jal  = 1'b1;
                imm     = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
            end
            default: begin
            end
        endcase
    end

    // Write-first read with x0 hardwired to zero
    function automatic logic [bp_pkg::XLEN-1:0] rf_read(
        input logic [bp_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (wb_wren_i && (wb_rd_i == addr)) begin
            return wb_data_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = rf_read(ifid_insn_i.r.rs1);
        rs2_data = rf_read(ifid_insn_i.r.rs2);
    end

    always_ff @(posedge clk_i) begin
        if (wb_wren_i && (wb_rd_i != '0)) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // ID/EX controls clear to a bubble on reset or flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            idex_vld_o        <= 1'b0;
            idex_rd_wren_o    <= 1'b0;
            idex_is_branch_o  <= 1'b0;
            idex_is_jal_o     <= 1'b0;
            idex_pred_taken_o <= 1'b0;
        end else if (flush_i) begin
            idex_vld_o        <= 1'b0;
            idex_rd_wren_o    <= 1'b0;
            idex_is_branch_o  <= 1'b0;
            idex_is_jal_o     <= 1'b0;
            idex_pred_taken_o <= 1'b0;
        end else begin
            idex_vld_o        <= vld;
            idex_rd_wren_o    <= rd_wren;
            idex_is_branch_o  <= is_branch;
            idex_is_jal_o     <= is_jal;
            idex_pred_taken_o <= ifid_pred_taken_i;
        end
    end

    always_ff @(posedge clk_i) begin
        idex_pc_o       <= ifid_pc_i;
        idex_rs1_o      <= ifid_insn_i.r.rs1;
        idex_rs2_o      <= ifid_insn_i.r.rs2;
        idex_rs1_data_o <= rs1_data;
        idex_rs2_data_o <= rs2_data;
        idex_imm_o      <= imm;
        idex_rd_o       <= ifid_insn_i.r.rd;
        idex_use_imm_o  <= use_imm;
        idex_alu_op_o   <= alu_op;
        idex_funct3_o   <= funct3;
    end

endmodule

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter int BP_INDEX_W = 4
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            imem_we_i,
    input  logic [bp_pkg::IMEM_DEPTH_W-1:0] imem_waddr_i,
    input  logic [bp_pkg::XLEN-1:0]         imem_wdata_i,
    resolve_if.dst                          res,
    output bp_pkg::insn_t                   ifid_insn_o,
    output logic [bp_pkg::XLEN-1:0]         ifid_pc_o,
    output logic                            ifid_pred_taken_o
);

    logic [bp_pkg::XLEN-1:0] imem [2 ** bp_pkg::IMEM_DEPTH_W];

    logic [bp_pkg::XLEN-1:0] pc_q;
    logic [bp_pkg::XLEN-1:0] pc_next;
    logic [bp_pkg::XLEN-1:0] pc_plus4;
    logic [bp_pkg::XLEN-1:0] recover_pc;
    logic [bp_pkg::XLEN-1:0] pred_target;
    logic                    pred_taken;
    bp_pkg::insn_t           insn;

    branch_predictor #(
        .BP_INDEX_W (BP_INDEX_W)
    ) i_branch_predictor (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_pc_i    (pc_q),
        .res           (res),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    assign pc_plus4   = pc_q + 32'd4;
    assign recover_pc = res.taken ? res.target : res.pc_plus4;

    always_comb begin
        if (res.mispredict) begin
            pc_next = recover_pc;
        end else if (pred_taken) begin
            pc_next = pred_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    // Program load port for use while the core sits in reset
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[imem_waddr_i] <= imem_wdata_i;
        end
    end

    assign insn = imem[pc_q[bp_pkg::IMEM_DEPTH_W+1:2]];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    // All-zero word decodes as invalid, so it doubles as the bubble
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ifid_insn_o       <= '0;
            ifid_pc_o         <= '0;
            ifid_pred_taken_o <= 1'b0;
        end else if (res.mispredict) begin
            ifid_insn_o       <= '0;
            ifid_pc_o         <= '0;
            ifid_pred_taken_o <= 1'b0;
        end else begin
            ifid_insn_o       <= insn;
            ifid_pc_o         <= pc_q;
            ifid_pred_taken_o <= pred_taken;
        end
    end

endmodule

`default_nettype wire

// File: verilog/branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor #(
    parameter int BP_INDEX_W = 4
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic [bp_pkg::XLEN-1:0] fetch_pc_i,
    resolve_if.dst                  res,
    output logic                    pred_taken_o,
    output logic [bp_pkg::XLEN-1:0] pred_target_o
);

    localparam int ENTRIES = 2 ** BP_INDEX_W;
    localparam int TAG_W   = bp_pkg::XLEN - BP_INDEX_W - 2;

    logic [ENTRIES-1:0][1:0]  pht;
    logic [ENTRIES-1:0]       btb_vld;
    logic [TAG_W-1:0]         btb_tag [ENTRIES];
    logic [bp_pkg::XLEN-1:0]  btb_target [ENTRIES];

    logic [BP_INDEX_W-1:0] rd_idx;
    logic [BP_INDEX_W-1:0] wr_idx;
    logic [TAG_W-1:0]      rd_tag;
    logic [TAG_W-1:0]      wr_tag;

    // Index sits just above the byte offset and the tag is the rest
    assign rd_idx = fetch_pc_i[BP_INDEX_W+1:2];
    assign rd_tag = fetch_pc_i[bp_pkg::XLEN-1:BP_INDEX_W+2];
    assign wr_idx = res.pc[BP_INDEX_W+1:2];
    assign wr_tag = res.pc[bp_pkg::XLEN-1:BP_INDEX_W+2];

    // Taken only on a tag hit with a weakly or strongly taken counter
    assign pred_taken_o  = btb_vld[rd_idx] && (btb_tag[rd_idx] == rd_tag) && pht[rd_idx][1];
    assign pred_target_o = btb_target[rd_idx];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pht     <= '0;
            btb_vld <= '0;
        end else if (res.is_ctrl) begin
            if (res.taken) begin
                btb_vld[wr_idx] <= 1'b1;
                if (pht[wr_idx] != 2'd3) begin
                    pht[wr_idx] <= pht[wr_idx] + 2'd1;
                end
            end else if (pht[wr_idx] != 2'd0) begin
                pht[wr_idx] <= pht[wr_idx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (res.is_ctrl && res.taken) begin
            btb_tag[wr_idx]    <= wr_tag;
            btb_target[wr_idx] <= res.target;
        end
    end

endmodule

`default_nettype wire

// File: verilog/resolve_if.sv
`timescale 1ns/10ps
`default_nettype none

// Resolved control transfer sitting in EX/MEM
interface resolve_if;

    logic                    is_ctrl;
    logic                    taken;
    logic                    mispredict;
    logic [bp_pkg::XLEN-1:0] pc;
    logic [bp_pkg::XLEN-1:0] target;
    logic [bp_pkg::XLEN-1:0] pc_plus4;

    modport src (output is_ctrl, taken, mispredict, pc, target, pc_plus4);
    modport dst (input is_ctrl, taken, mispredict, pc, target, pc_plus4);

endinterface

`default_nettype wire

// File: verilog/bp_pkg.sv
`default_nettype none

package bp_pkg;

    localparam int XLEN         = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int IMEM_DEPTH_W = 4;

    // RV32I major opcodes in use
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;
    localparam logic [2:0] ALU_SLT = 3'd5;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } insn_r_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } insn_i_t;

    // One 32-bit word seen as register fields or as an I-immediate
    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_t;

endpackage

`default_nettype wire
